// ==== Makefile ====
TB_TOP = wave_player_tb

.PHONY: all lint sim clean

all: sim

# The RTL top is linted in both reader modes
lint:
	verilator --lint-only --timing --assert -f wave_player.f --top-module $(TB_TOP)
	verilator --lint-only --timing --assert -f wave_player.f --top-module wave_player_top -Gcontinuous=0
	verilator --lint-only --timing --assert -f wave_player.f --top-module wave_player_top -Gcontinuous=1

sim:
	verilator --binary --timing --assert -f wave_player.f --top-module $(TB_TOP) -o $(TB_TOP)
	@out="$$(./obj_dir/$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// ==== hdl/axis_bram_reader.sv ====
`timescale 1ns/10ps
`include "wave_player_params.svh"

module axis_bram_reader
  import wave_player_pkg::*;
#(
  parameter bit continuous = `WP_CONTINUOUS
)
(
  input  logic    aclk,
  input  logic    aresetn,
  input  addr_t   cfg_last,
  input  logic    m_axis_tready,
  output sample_t m_axis_tdata,
  output logic    m_axis_tvalid,
  output logic    m_axis_tlast,
  output addr_t   rd_addr,
  input  sample_t rd_data
);

  reader_state_t state;
  reader_state_t state_next;
  addr_t         counter;
  addr_t         counter_next;

  // Counter is below the last index, so there is more to play
  logic more;

  // Counter sits on the last index
  logic at_last;

  // A beat is accepted this cycle
  logic beat;

  // Reader leaves idle this cycle
  logic start;

  // Value of counter and state after the tlast beat, set by the mode
  addr_t         end_counter;
  reader_state_t end_state;

  // Counter already played its word, so a restart moves on by one
  logic resume_step;

  assign more    = counter < cfg_last;
  assign at_last = counter == cfg_last;
  assign beat    = (state == stream) && m_axis_tready;
  assign start   = (state == idle) && more;

  generate
    if (continuous)
    begin : g_wrap
      // Play the buffer again from address 0
      assign end_counter = '0;
      assign end_state   = stream;
      assign resume_step = 1'b0;
    end
    else
    begin : g_stop
      logic drained;

      // Set once the tlast beat has gone out, cleared again on restart
      always_ff @(posedge aclk)
      begin
        if (!aresetn)
        begin
          drained <= 1'b0;
        end
        else if (start)
        begin
          drained <= 1'b0;
        end
        else if (beat && at_last)
        begin
          drained <= 1'b1;
        end
      end

      // Halt on the last index and wait for the host to raise cfg_last
      assign end_counter = counter;
      assign end_state   = idle;
      assign resume_step = drained;
    end
  endgenerate

  always_comb
  begin
    counter_next = counter;
    state_next   = state;
    if (start)
    begin
      state_next = stream;
      if (resume_step)
      begin
        counter_next = counter + 1'b1;
      end
    end
    else if (beat)
    begin
      if (at_last)
      begin
        counter_next = end_counter;
        state_next   = end_state;
      end
      else if (more)
      begin
        counter_next = counter + 1'b1;
      end
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      counter <= '0;
      state   <= idle;
    end
    else
    begin
      counter <= counter_next;
      state   <= state_next;
    end
  end

  // The RAM is fed the counter value of the next cycle, so its registered
  // output lines up with counter and accepted beats go out back to back
  assign rd_addr = counter_next;

  assign m_axis_tdata  = rd_data;
  assign m_axis_tvalid = state == stream;
  assign m_axis_tlast  = (state == stream) && at_last;

endmodule

// ==== hdl/sample_bram.sv ====
`timescale 1ns/10ps

module sample_bram
  import wave_player_pkg::*;
(
  input  logic    aclk,
  input  logic    wr_en,
  input  addr_t   wr_addr,
  input  sample_t wr_data,
  input  addr_t   rd_addr,
  output sample_t rd_data
);

  localparam int depth = 2 ** $bits(addr_t);

  // Sample storage, one write port and one read port on the same clock
  sample_t mem [0:depth-1];

  // Write port
  always_ff @(posedge aclk)
  begin
    if (wr_en)
    begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port
  // A read of the address being written returns the old word
  always_ff @(posedge aclk)
  begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== hdl/sample_loader.sv ====
`timescale 1ns/10ps

module sample_loader
  import wave_player_pkg::*;
(
  input  logic    aclk,
  input  logic    aresetn,
  input  logic    load_clear,
  input  logic    load_valid,
  input  sample_t load_data,
  output logic    wr_en,
  output addr_t   wr_addr,
  output sample_t wr_data,
  output addr_t   fill_count
);

  // The fill counter cannot represent the full depth in addr_t,
  // so it stops one word short of it
  localparam addr_t fill_max = '1;

  // Address that the next host word goes to
  addr_t next_addr;

  // Address for a write in this cycle, with a clear taking effect at once
  addr_t base_addr;

  assign base_addr = load_clear ? '0 : next_addr;

  // Write strobe, write address and the running address counter
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_en     <= 1'b0;
      wr_addr   <= '0;
      next_addr <= '0;
    end
    else
    begin
      wr_en <= load_valid;
      if (load_valid)
      begin
        wr_addr   <= base_addr;
        next_addr <= base_addr + 1'b1;
      end
      else if (load_clear)
      begin
        next_addr <= '0;
      end
    end
  end

  // Fill level moves on the same edge that issues the RAM write
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      fill_count <= '0;
    end
    else if (load_clear)
    begin
      fill_count <= addr_t'(load_valid);
    end
    else if (load_valid && (fill_count != fill_max))
    begin
      fill_count <= fill_count + 1'b1;
    end
  end

  // Payload is only captured when a word arrives
  always_ff @(posedge aclk)
  begin
    if (load_valid)
    begin
      wr_data <= load_data;
    end
  end

endmodule

// ==== hdl/wave_player_params.svh ====
`ifndef WAVE_PLAYER_PARAMS_SVH
`define WAVE_PLAYER_PARAMS_SVH

// Width of one sample word, as stored in the RAM and sent on tdata
`define WP_SAMPLE_WIDTH 32

// RAM address width, which also sets the buffer depth to 2**WP_ADDR_WIDTH words
`define WP_ADDR_WIDTH 10

// Reader behaviour after the last beat
// 0 plays the buffer once and halts
// 1 wraps back to address 0 and keeps playing
`define WP_CONTINUOUS 0

`endif

// ==== hdl/wave_player_pkg.sv ====
`include "wave_player_params.svh"

package wave_player_pkg;

  // One sample word, used for the RAM data and for the stream payload
  typedef logic [`WP_SAMPLE_WIDTH-1:0] sample_t;

  // RAM address, also used for the fill level and the last play index
  typedef logic [`WP_ADDR_WIDTH-1:0] addr_t;

  // Enable state of the streaming reader
  // In stream the reader holds tvalid high
  typedef enum logic
  {
    idle   = 1'b0,
    stream = 1'b1
  } reader_state_t;

endpackage

// ==== hdl/wave_player_top.sv ====
`timescale 1ns/10ps
`include "wave_player_params.svh"

module wave_player_top
  import wave_player_pkg::*;
#(
  parameter bit continuous = `WP_CONTINUOUS
)
(
  input  logic    aclk,
  input  logic    aresetn,

  // Host load side
  input  logic    load_clear,
  input  logic    load_valid,
  input  sample_t load_data,
  output addr_t   fill_count,

  // Playback control, held by the host
  input  addr_t   cfg_last,

  // Stream master
  input  logic    m_axis_tready,
  output sample_t m_axis_tdata,
  output logic    m_axis_tvalid,
  output logic    m_axis_tlast
);

  // RAM write port from the loader
  logic    wr_en;
  addr_t   wr_addr;
  sample_t wr_data;

  // RAM read port to the reader
  addr_t   rd_addr;
  sample_t rd_data;

  sample_loader u_loader
  (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .load_clear (load_clear),
    .load_valid (load_valid),
    .load_data  (load_data),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .fill_count (fill_count)
  );

  sample_bram u_bram
  (
    .aclk    (aclk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  axis_bram_reader #(
    .continuous (continuous)
  ) u_reader
  (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .cfg_last      (cfg_last),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data)
  );

endmodule

// ==== verif/wave_player_chk.sv ====
`timescale 1ns/10ps

module wave_player_chk
  import wave_player_pkg::*;
(
  input logic    aclk,
  input logic    aresetn,
  input logic    m_axis_tvalid,
  input logic    m_axis_tready,
  input logic    m_axis_tlast,
  input sample_t m_axis_tdata,
  input addr_t   rd_addr,
  input addr_t   counter
);

  // A stalled beat keeps its payload until the sink takes it
  a_stall_holds: assert property (@(posedge aclk) disable iff (!aresetn)
    m_axis_tvalid && !m_axis_tready |=> $stable(m_axis_tdata) && $stable(m_axis_tlast))
    else $error("Stream payload changed while the beat was stalled");

  a_last_needs_valid: assert property (@(posedge aclk) disable iff (!aresetn)
    m_axis_tlast |-> m_axis_tvalid)
    else $error("tlast raised without tvalid");

  // Look-ahead address lets the next word come out without a bubble
  a_look_ahead: assert property (@(posedge aclk) disable iff (!aresetn)
    m_axis_tvalid && m_axis_tready && !m_axis_tlast |-> rd_addr == counter + addr_t'(1))
    else $error("RAM read address is not one ahead of the accepted beat");

endmodule

bind axis_bram_reader wave_player_chk u_chk
(
  .aclk          (aclk),
  .aresetn       (aresetn),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tready (m_axis_tready),
  .m_axis_tlast  (m_axis_tlast),
  .m_axis_tdata  (m_axis_tdata),
  .rd_addr       (rd_addr),
  .counter       (counter)
);

// ==== verif/wave_player_tb.sv ====
`timescale 1ns/10ps
`include "wave_player_params.svh"

module wave_player_tb
  import wave_player_pkg::*;
();

  // Room for about 800 beats at 70% ready plus the load phases and idle checks
  localparam int max_cycles = 4000;

  logic    aclk;
  logic    aresetn;
  logic    load_clear;
  logic    load_valid;
  sample_t load_data;
  addr_t   fill_count;
  addr_t   cfg_last;
  logic    m_axis_tready;
  sample_t m_axis_tdata;
  logic    m_axis_tvalid;
  logic    m_axis_tlast;

  int      seed = 32'h112d;
  logic    random_ready;
  sample_t model [0:(2 ** `WP_ADDR_WIDTH)-1];
  addr_t   wr_ptr;
  addr_t   play_idx;
  int      beat_count;
  int      first_cycle;
  int      last_cycle;
  int      cycle;
  int      error_count;

  wave_player_top #(
    .continuous (1'b0)
  ) u_dut (.*);

  always #10 aclk = ~aclk;

  // Expected tlast sits in the top bit with the sample below it
  function automatic logic [`WP_SAMPLE_WIDTH:0] expected_beat(input addr_t idx,
                                                              input addr_t last_idx);
    return {idx == last_idx, model[idx]};
  endfunction

  always @(posedge aclk)
  begin
    cycle <= cycle + 1;
    if (cycle == max_cycles)
    begin
      $display("Timeout after %0d cycles with %0d beats received, errors: %0d",
               cycle, beat_count, error_count);
      $display("Finished with errors");
      $finish;
    end
  end

  // Sink back-pressure keeps tready high about 70% of the time when enabled
  always @(posedge aclk)
  begin
    if (random_ready)
      m_axis_tready <= ($unsigned($random(seed)) % 10) < 7;
    else
      m_axis_tready <= 1'b1;
  end

  always @(posedge aclk)
  begin : compare_beats
    logic [`WP_SAMPLE_WIDTH:0] exp;
    if (aresetn && m_axis_tvalid && m_axis_tready)
    begin
      exp = expected_beat(play_idx, cfg_last);
      assert (play_idx <= cfg_last) else
      begin
        error_count++;
        $display("Beat at %0d ns arrived after the last index %0d", $time, cfg_last);
      end
      assert (m_axis_tdata == exp[`WP_SAMPLE_WIDTH-1:0]) else
      begin
        error_count++;
        $display("mismatch at %0d ns: m_axis_tdata index %0d expected %h actual %h",
                 $time, play_idx, exp[`WP_SAMPLE_WIDTH-1:0], m_axis_tdata);
      end
      assert (m_axis_tlast == exp[`WP_SAMPLE_WIDTH]) else
      begin
        error_count++;
        $display("mismatch at %0d ns: m_axis_tlast index %0d expected %b actual %b",
                 $time, play_idx, exp[`WP_SAMPLE_WIDTH], m_axis_tlast);
      end
      if (play_idx == '0)
        first_cycle <= cycle;
      if (m_axis_tlast)
        last_cycle <= cycle;
      play_idx   <= play_idx + addr_t'(1);
      beat_count <= beat_count + 1;
    end
  end

  task automatic load_words(input int count);
    int      i;
    sample_t word;
    for (i = 0; i < count; i++)
    begin
      word = $random(seed);
      @(posedge aclk);
      load_valid <= 1'b1;
      load_data  <= word;
      model[wr_ptr] = word;
      wr_ptr = wr_ptr + addr_t'(1);
    end
    @(posedge aclk);
    load_valid <= 1'b0;
  endtask

  task automatic clear_load;
    @(posedge aclk);
    load_clear <= 1'b1;
    @(posedge aclk);
    load_clear <= 1'b0;
    wr_ptr = '0;
  endtask

  task automatic check_fill(input addr_t expected);
    repeat (3) @(posedge aclk);
    assert (fill_count == expected) else
    begin
      error_count++;
      $display("mismatch at %0d ns: fill_count expected %0d actual %0d",
               $time, expected, fill_count);
    end
  endtask

  task automatic expect_idle(input int cycles);
    repeat (cycles)
    begin
      @(posedge aclk);
      assert (!m_axis_tvalid && !m_axis_tlast) else
      begin
        error_count++;
        $display("mismatch at %0d ns: m_axis_tvalid/m_axis_tlast expected 0/0 actual %b/%b",
                 $time, m_axis_tvalid, m_axis_tlast);
      end
    end
  endtask

  task automatic wait_beats(input int target);
    while (beat_count < target)
      @(posedge aclk);
  endtask

  initial
  begin
    aclk          = 1'b0;
    aresetn       = 1'b0;
    load_clear    = 1'b0;
    load_valid    = 1'b0;
    load_data     = '0;
    cfg_last      = '0;
    m_axis_tready = 1'b1;
    random_ready  = 1'b0;
    wr_ptr        = '0;
    play_idx      = '0;
    beat_count    = 0;
    first_cycle   = 0;
    last_cycle    = 0;
    cycle         = 0;
    error_count   = 0;
    repeat (10) @(posedge aclk);
    aresetn <= 1'b1;
    expect_idle(5);
    check_fill(wr_ptr);

    // Loaded buffer must not play while cfg_last is 0
    clear_load;
    load_words(64);
    check_fill(wr_ptr);
    expect_idle(10);

    cfg_last <= addr_t'(63);
    wait_beats(64);
    expect_idle(50);
    assert (beat_count == 64 && last_cycle - first_cycle == 63) else
    begin
      error_count++;
      $display("First pass gave %0d beats over %0d cycles instead of 64 back to back",
               beat_count, last_cycle - first_cycle + 1);
    end

    // Resume from index 64 under back-pressure
    load_words(100);
    check_fill(wr_ptr);
    random_ready <= 1'b1;
    cfg_last     <= addr_t'(150);
    wait_beats(151);
    expect_idle(10);
    random_ready <= 1'b0;
    assert (beat_count == 151) else
    begin
      error_count++;
      $display("Second pass ended with %0d beats in total instead of 151", beat_count);
    end

    clear_load;
    load_words(20);
    check_fill(wr_ptr);

    $display("Errors: %0d", error_count);
    if (error_count == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// ==== wave_player.f ====
+incdir+hdl
hdl/wave_player_pkg.sv
hdl/sample_loader.sv
hdl/sample_bram.sv
hdl/axis_bram_reader.sv
hdl/wave_player_top.sv
verif/wave_player_chk.sv
verif/wave_player_tb.sv
